/* Bender.yml */
package:
  name: rs_lite

sources:
  - rs_lite_pkg.sv
  - rs_lite_control.sv
  - rs_lite_pc.sv
  - rs_lite_decode.sv
  - rs_lite_regbank.sv
  - rs_lite_execute.sv
  - rs_lite.sv
  - target: test
    files:
      - tb_rs_lite.sv

/* rs_lite.f */
rs_lite_pkg.sv
rs_lite_control.sv
rs_lite_pc.sv
rs_lite_decode.sv
rs_lite_regbank.sv
rs_lite_execute.sv
rs_lite.sv
tb_rs_lite.sv

/* rs_lite.sv */
`default_nettype none

module rs_lite #(
    parameter rs_lite_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               stall_i,
    input  rs_lite_pkg::word_t instruction_i,
    input  rs_lite_pkg::word_t mem_data_i,
    output rs_lite_pkg::word_t instruction_address_o,
    output rs_lite_pkg::word_t mem_address_o,
    output rs_lite_pkg::word_t mem_data_o,
    output logic               mem_operation_enable_o,
    output logic [3:0]         mem_write_enable_o
);
    import rs_lite_pkg::*;

    // Step strobes, fetch needs no consumer since PC is always on the bus
    logic      decode_en, execute_en, mem_en, wb_en;
    decoded_t  decoded;
    word_t     pc;
    logic      branch_taken;
    word_t     target;
    word_t     rs1_data, rs2_data;
    mem_req_t  mem_req;
    logic      rd_we;
    reg_addr_t rd;
    word_t     rd_data;

    ////////////////////////////////////////////////////////////
    // Control and fetch
    ////////////////////////////////////////////////////////////

    rs_lite_control control0 (
        .clk(clk), .reset_i(reset_i), .stall_i(stall_i), .op_i(decoded.op),
        .fetch_en_o(), .decode_en_o(decode_en), .execute_en_o(execute_en),
        .mem_en_o(mem_en), .wb_en_o(wb_en)
    );

    rs_lite_pc #(.RESET_PC(RESET_PC)) pc0 (
        .clk(clk), .reset_i(reset_i), .stall_i(stall_i), .wb_en_i(wb_en),
        .branch_taken_i(branch_taken), .target_i(target), .pc_o(pc)
    );

    ////////////////////////////////////////////////////////////
    // Decode, register bank, execute
    ////////////////////////////////////////////////////////////

    rs_lite_decode decode0 (
        .clk(clk), .reset_i(reset_i), .stall_i(stall_i), .decode_en_i(decode_en),
        .instruction_i(instruction_i), .decoded_o(decoded)
    );

    rs_lite_regbank regbank0 (
        .clk(clk), .reset_i(reset_i), .stall_i(stall_i), .we_i(rd_we),
        .rs1_i(decoded.rs1), .rs2_i(decoded.rs2), .rd_i(rd), .wdata_i(rd_data),
        .rs1_data_o(rs1_data), .rs2_data_o(rs2_data)
    );

    rs_lite_execute execute0 (
        .clk(clk), .reset_i(reset_i), .stall_i(stall_i),
        .execute_en_i(execute_en), .mem_en_i(mem_en), .wb_en_i(wb_en),
        .decoded_i(decoded), .pc_i(pc), .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
        .mem_rdata_i(mem_data_i), .branch_taken_o(branch_taken), .target_o(target),
        .mem_req_o(mem_req), .rd_we_o(rd_we), .rd_o(rd), .rd_data_o(rd_data)
    );

    // Memory ports
    assign instruction_address_o  = pc;
    assign mem_operation_enable_o = mem_req.enable;
    assign mem_write_enable_o     = mem_req.write_strobe;
    assign mem_address_o          = mem_req.address;
    assign mem_data_o             = mem_req.wdata;

endmodule

`default_nettype wire

/* rs_lite_control.sv */
`default_nettype none

module rs_lite_control (
    input  logic             clk,
    input  logic             reset_i,
    input  logic             stall_i,
    input  rs_lite_pkg::op_e op_i,
    output logic             fetch_en_o,
    output logic             decode_en_o,
    output logic             execute_en_o,
    output logic             mem_en_o,
    output logic             wb_en_o
);
    import rs_lite_pkg::*;

    state_e state_q;
    state_e state_d;

    ////////////////////////////////////////////////////////////
    // State sequencing
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_fetch:     state_d = st_decode;
            st_decode:    state_d = st_execute;
            // Only word loads and stores touch data memory
            st_execute: begin
                if (op_i == op_lw || op_i == op_sw) begin
                    state_d = st_memory;
                end else begin
                    state_d = st_writeback;
                end
            end
            st_memory:    state_d = st_writeback;
            st_writeback: state_d = st_fetch;
            default:      state_d = st_fetch;
        endcase
    end

    // Stall freezes the sequence in place
    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= st_fetch;
        end else if (!stall_i) begin
            state_q <= state_d;
        end
    end

    // One strobe per state
    assign fetch_en_o   = (state_q == st_fetch);
    assign decode_en_o  = (state_q == st_decode);
    assign execute_en_o = (state_q == st_execute);
    assign mem_en_o     = (state_q == st_memory);
    assign wb_en_o      = (state_q == st_writeback);

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    a_state_legal: assert property (@(posedge clk) disable iff (reset_i)
        state_q inside {st_fetch, st_decode, st_execute, st_memory, st_writeback});

    a_strobe_onehot: assert property (@(posedge clk) disable iff (reset_i)
        $onehot0({fetch_en_o, decode_en_o, execute_en_o, mem_en_o, wb_en_o}));

endmodule

`default_nettype wire

/* rs_lite_decode.sv */
`default_nettype none

module rs_lite_decode (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  stall_i,
    input  logic                  decode_en_i,
    input  rs_lite_pkg::word_t    instruction_i,
    output rs_lite_pkg::decoded_t decoded_o
);
    import rs_lite_pkg::*;

    word_t      ir_q;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    op_e        op;
    word_t      imm;

    ////////////////////////////////////////////////////////////
    // Instruction register
    ////////////////////////////////////////////////////////////

    // Sync instruction memory answers in decode
    // Zero word decodes as a no-op
    always_ff @(posedge clk) begin
        if (reset_i) begin
            ir_q <= '0;
        end else if (decode_en_i && !stall_i) begin
            ir_q <= instruction_i;
        end
    end

    assign opcode = ir_q[6:0];
    assign funct3 = ir_q[14:12];
    assign funct7 = ir_q[31:25];

    ////////////////////////////////////////////////////////////
    // Operation and immediate
    ////////////////////////////////////////////////////////////

    always_comb begin
        op = op_nop;
        case (opcode)
            opc_lui:    op = op_lui;
            opc_op_imm: if (funct3 == 3'b000) op = op_addi;
            opc_load:   if (funct3 == 3'b010) op = op_lw;
            opc_store:  if (funct3 == 3'b010) op = op_sw;
            opc_jal:    op = op_jal;
            opc_branch: begin
                if (funct3 == 3'b000) op = op_beq;
                if (funct3 == 3'b001) op = op_bne;
            end
            // R-type, SUB is the only one with funct7 bit 5 set
            opc_op: begin
                if (funct7 == 7'b0000000) begin
                    case (funct3)
                        3'b000:  op = op_add;
                        3'b100:  op = op_xor;
                        3'b110:  op = op_or;
                        3'b111:  op = op_and;
                        default: op = op_nop;
                    endcase
                end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    op = op_sub;
                end
            end
            default:    op = op_nop;
        endcase
    end

    // Immediate layout by format
    always_comb begin
        case (op)
            op_lui:         imm = {ir_q[31:12], 12'b0};
            op_sw:          imm = {{20{ir_q[31]}}, ir_q[31:25], ir_q[11:7]};
            op_beq, op_bne: imm = {{19{ir_q[31]}}, ir_q[31], ir_q[7],
                                   ir_q[30:25], ir_q[11:8], 1'b0};
            op_jal:         imm = {{11{ir_q[31]}}, ir_q[31], ir_q[19:12],
                                   ir_q[20], ir_q[30:21], 1'b0};
            default:        imm = {{20{ir_q[31]}}, ir_q[31:20]};  // I-type
        endcase
    end

    assign decoded_o.op  = op;
    assign decoded_o.rd  = ir_q[11:7];
    assign decoded_o.rs1 = ir_q[19:15];
    assign decoded_o.rs2 = ir_q[24:20];
    assign decoded_o.imm = imm;

    // x0 target never produces a write
    assign decoded_o.writes_rd = !(op inside {op_sw, op_beq, op_bne, op_nop})
                                 && (ir_q[11:7] != '0);

endmodule

`default_nettype wire

/* rs_lite_execute.sv */
`default_nettype none

module rs_lite_execute (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   stall_i,
    input  logic                   execute_en_i,
    input  logic                   mem_en_i,
    input  logic                   wb_en_i,
    input  rs_lite_pkg::decoded_t  decoded_i,
    input  rs_lite_pkg::word_t     pc_i,
    input  rs_lite_pkg::word_t     rs1_data_i,
    input  rs_lite_pkg::word_t     rs2_data_i,
    input  rs_lite_pkg::word_t     mem_rdata_i,
    output logic                   branch_taken_o,
    output rs_lite_pkg::word_t     target_o,
    output rs_lite_pkg::mem_req_t  mem_req_o,
    output logic                   rd_we_o,
    output rs_lite_pkg::reg_addr_t rd_o,
    output rs_lite_pkg::word_t     rd_data_o
);
    import rs_lite_pkg::*;

    word_t alu_res;
    logic  take;
    word_t result_q;  // ALU result, link value or load/store address
    word_t wdata_q;
    word_t target_q;
    logic  taken_q;

    ////////////////////////////////////////////////////////////
    // ALU and branch compare
    ////////////////////////////////////////////////////////////

    always_comb begin
        alu_res = '0;
        take    = 1'b0;
        case (decoded_i.op)
            op_lui:               alu_res = decoded_i.imm;
            op_addi, op_lw, op_sw: alu_res = rs1_data_i + decoded_i.imm;
            op_add:               alu_res = rs1_data_i + rs2_data_i;
            op_sub:               alu_res = rs1_data_i - rs2_data_i;
            op_and:               alu_res = rs1_data_i & rs2_data_i;
            op_or:                alu_res = rs1_data_i | rs2_data_i;
            op_xor:               alu_res = rs1_data_i ^ rs2_data_i;
            op_beq:               take    = (rs1_data_i == rs2_data_i);
            op_bne:               take    = (rs1_data_i != rs2_data_i);
            op_jal: begin
                alu_res = pc_i + 32'd4;
                take    = 1'b1;
            end
            default: ;
        endcase
    end

    // Capture everything at the end of execute
    always_ff @(posedge clk) begin
        if (reset_i) begin
            taken_q <= 1'b0;
        end else if (execute_en_i && !stall_i) begin
            taken_q <= take;
        end
    end

    always_ff @(posedge clk) begin
        if (execute_en_i && !stall_i) begin
            result_q <= alu_res;
            wdata_q  <= rs2_data_i;
            target_q <= pc_i + decoded_i.imm;
        end
    end

    assign branch_taken_o = taken_q;
    assign target_o       = target_q;

    ////////////////////////////////////////////////////////////
    // Data memory request
    ////////////////////////////////////////////////////////////

    // Enable dropped while stalled so the access repeats on release
    assign mem_req_o.enable       = mem_en_i && !stall_i;
    assign mem_req_o.write_strobe = (mem_en_i && decoded_i.op == op_sw) ? 4'hF : 4'h0;
    assign mem_req_o.address      = result_q;
    assign mem_req_o.wdata        = wdata_q;

    // Writeback select, load data arrives one cycle after the request
    assign rd_we_o   = wb_en_i && !stall_i && decoded_i.writes_rd;
    assign rd_o      = decoded_i.rd;
    assign rd_data_o = (decoded_i.op == op_lw) ? mem_rdata_i : result_q;

endmodule

`default_nettype wire

/* rs_lite_golden.txt */
// Each record is a kind word followed by four words
// Kind 1 is program and kind 2 is data preload, both as address then three words
// Kind 3 is two expected stores as address and data pairs in order
// Kind 0 ends the list
1 00000000 123450B7 67808193 F1000113
1 0000000C 20000513 00152023 00352223
1 00000018 00218233 00452423 402182B3
1 00000024 00552623 0021F333 00652823
1 00000030 0021E3B3 00752A23 0021C433
1 0000003C 00852C23 10002483 00952E23
1 00000048 ABCDE037 02052023 00418463
1 00000054 02352223 00948463 02052423
1 00000060 00949463 02252423 00419463
1 0000006C 02052623 008005EF 02052623
1 00000078 02B52623 0000006F 00000013
2 00000100 CAFEF00D 0BADBEEF 13579BDF
3 00000200 12345000 00000204 12345678
3 00000208 12345588 0000020C 12345768
3 00000210 12345610 00000214 FFFFFF78
3 00000218 EDCBA968 0000021C CAFEF00D
3 00000220 00000000 00000224 12345678
3 00000228 FFFFFF10 0000022C 00000074
0 00000000 00000000 00000000 00000000

/* rs_lite_pc.sv */
`default_nettype none

module rs_lite_pc #(
    parameter rs_lite_pkg::word_t RESET_PC = '0
) (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               stall_i,
    input  logic               wb_en_i,
    input  logic               branch_taken_i,
    input  rs_lite_pkg::word_t target_i,
    output rs_lite_pkg::word_t pc_o
);
    import rs_lite_pkg::*;

    word_t pc_q;

    // PC only moves at the end of writeback
    // Taken branch or JAL loads the target, otherwise next word
    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q <= RESET_PC;
        end else if (wb_en_i && !stall_i) begin
            if (branch_taken_i) begin
                pc_q <= target_i;
            end else begin
                pc_q <= pc_q + 32'd4;
            end
        end
    end

    assign pc_o = pc_q;

    // No compressed support, so fetch must stay on word boundaries
    a_pc_aligned: assert property (@(posedge clk) disable iff (reset_i)
        pc_o[1:0] == 2'b00);

endmodule

`default_nettype wire

/* rs_lite_pkg.sv */
`default_nettype none

package rs_lite_pkg;

    // Core widths
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    // RV32I major opcodes, bits 6:0 of the instruction word
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal    = 7'b1101111;

    // Decoded operation, anything unsupported ends up as op_nop
    typedef enum logic [3:0] {
        op_lui, op_addi, op_add, op_sub, op_and, op_or, op_xor,
        op_lw, op_sw, op_beq, op_bne, op_jal, op_nop
    } op_e;

    // One state per instruction step
    typedef enum logic [2:0] {
        st_fetch, st_decode, st_execute, st_memory, st_writeback
    } state_e;

    typedef struct packed {
        op_e       op;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        word_t     imm;        // Sign extended, format already applied
        logic      writes_rd;  // Cleared for rd == x0
    } decoded_t;

    typedef struct packed {
        logic       enable;
        logic [3:0] write_strobe;
        word_t      address;
        word_t      wdata;
    } mem_req_t;

endpackage

`default_nettype wire

/* rs_lite_regbank.sv */
`default_nettype none

module rs_lite_regbank (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   stall_i,
    input  logic                   we_i,
    input  rs_lite_pkg::reg_addr_t rs1_i,
    input  rs_lite_pkg::reg_addr_t rs2_i,
    input  rs_lite_pkg::reg_addr_t rd_i,
    input  rs_lite_pkg::word_t     wdata_i,
    output rs_lite_pkg::word_t     rs1_data_o,
    output rs_lite_pkg::word_t     rs2_data_o
);
    import rs_lite_pkg::*;

    // x1..x31 only, x0 has no storage
    word_t regs_q [1:31];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && !stall_i && rd_i != '0) begin
            regs_q[rd_i] <= wdata_i;
        end
    end

    // Async read ports
    assign rs1_data_o = (rs1_i == '0) ? '0 : regs_q[rs1_i];
    assign rs2_data_o = (rs2_i == '0) ? '0 : regs_q[rs2_i];

    // Decode already drops x0 writes before they reach writeback
    a_no_x0_write: assert property (@(posedge clk) disable iff (reset_i)
        !(we_i && rd_i == '0));

endmodule

`default_nettype wire

/* tb_rs_lite.sv */
`default_nettype none

module tb_rs_lite;
    timeunit 1ns;
    timeprecision 1ps;

    import rs_lite_pkg::*;

    localparam int golden_words  = 256;
    localparam int max_stores    = 64;
    localparam int store_timeout = 4000;

    logic       clk;
    logic       reset;
    logic       stall;
    word_t      instr;
    word_t      mem_rdata;
    word_t      instr_addr;
    word_t      mem_addr;
    word_t      mem_wdata;
    logic       mem_en;
    logic [3:0] mem_we;

    word_t golden [0:golden_words-1];
    word_t imem [0:63];
    word_t dmem [0:255];
    word_t exp_addr [0:max_stores-1];
    word_t exp_data [0:max_stores-1];
    int    n_stores;
    int    store_idx;
    word_t fetch_addr_q;
    word_t load_addr_q;
    logic  load_pending;
    logic  stall_on;

    rs_lite #(.RESET_PC(32'h0000_0000)) dut0 (
        .clk(clk), .reset_i(reset), .stall_i(stall),
        .instruction_i(instr), .mem_data_i(mem_rdata),
        .instruction_address_o(instr_addr), .mem_address_o(mem_addr),
        .mem_data_o(mem_wdata), .mem_operation_enable_o(mem_en),
        .mem_write_enable_o(mem_we)
    );

    // 20 ns period
    initial clk = 1'b0;
    always #10 clk = ~clk;

    task automatic end_with_failure();
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic compare_value(input word_t actual, input word_t expected, input string what);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            end_with_failure();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Golden file and memory images
    ////////////////////////////////////////////////////////////

    // Records of five words, kind first
    task automatic load_golden();
        int    i;
        int    k;
        word_t a;
        for (i = 0; i < golden_words; i++) begin
            golden[i] = '0;
        end
        // Fill words carry their own address
        for (i = 0; i < 64; i++) begin
            a = i * 4;
            imem[i] = {a[11:0], 13'b0, 7'b0010011};
        end
        for (i = 0; i < 256; i++) begin
            dmem[i] = 32'hD000_0000 | (i * 4);
        end
        $readmemh("rs_lite_golden.txt", golden);
        n_stores = 0;
        i = 0;
        while (i + 5 <= golden_words && golden[i] != 0) begin
            a = golden[i+1];
            case (golden[i])
                1: for (k = 0; k < 3; k++) imem[a[7:2] + k] = golden[i+2+k];
                2: for (k = 0; k < 3; k++) dmem[a[9:2] + k] = golden[i+2+k];
                3: begin
                    for (k = 0; k < 2; k++) begin
                        exp_addr[n_stores] = golden[i+1+2*k];
                        exp_data[n_stores] = golden[i+2+2*k];
                        n_stores++;
                    end
                end
                default: begin
                    $display("Golden file holds a record of unknown kind %h", golden[i]);
                    end_with_failure();
                end
            endcase
            i += 5;
        end
        if (n_stores == 0) begin
            $display("Golden file holds no expected stores");
            end_with_failure();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Memory models and store monitor
    ////////////////////////////////////////////////////////////

    // Both memories sample the bus on the rising edge
    always @(posedge clk) begin
        fetch_addr_q <= instr_addr;
        load_pending <= 1'b0;
        if (reset) begin
            store_idx <= 0;
        end else begin
            if (stall) compare_value({31'b0, mem_en}, '0, "data memory enable while stalled");
            if (mem_en && mem_we != 4'h0) begin
                if (store_idx >= n_stores) begin
                    $display("Store to %h came after the last golden store", mem_addr);
                    end_with_failure();
                end
                compare_value({28'b0, mem_we}, 32'hF, "store byte enables");
                compare_value(mem_addr, exp_addr[store_idx], "store address");
                compare_value(mem_wdata, exp_data[store_idx], "store data");
                dmem[mem_addr[9:2]] <= mem_wdata;
                store_idx <= store_idx + 1;
            end else if (mem_en) begin
                load_addr_q  <= mem_addr;
                load_pending <= 1'b1;
            end
        end
    end

    // Read data changes on the falling edge
    always @(negedge clk) begin
        instr = imem[fetch_addr_q[7:2]];
        if (load_pending) mem_rdata = dmem[load_addr_q[9:2]];
    end

    // Stall pulses from their own generator, seeded once
    initial begin
        int unsigned seed_val;
        seed_val = $urandom(32'h16d88bf2);
        forever begin
            @(negedge clk);
            stall = stall_on && (($urandom % 4) == 0);
        end
    end

    task automatic wait_for_stores();
        int cycles;
        cycles = 0;
        while (store_idx < n_stores) begin
            @(negedge clk);
            cycles++;
            if (cycles > store_timeout) begin
                $display("Timeout while waiting for stores, %0d of %0d golden stores seen",
                         store_idx, n_stores);
                end_with_failure();
            end
        end
    endtask

    initial begin
        reset     = 1'b1;
        stall     = 1'b0;
        stall_on  = 1'b0;
        instr     = '0;
        mem_rdata = '0;
        load_golden();
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        compare_value(instr_addr, 32'h0, "fetch address after reset");
        compare_value({31'b0, mem_en}, '0, "data memory enable after reset");
        @(posedge clk);
        stall_on = 1'b1;
        wait_for_stores();
        // Quiet period so a stray store past the list is caught
        repeat (50) @(negedge clk);
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire
